//--- design/video_pkg.sv
package video_pkg;

	// Width of one colour component at the output pins
	localparam int OUT_BITS = 6;

	// Scanline darkening applied on every second output line
	typedef enum logic [1:0] {
		SCAN_NONE,
		SCAN_25,
		SCAN_50,
		SCAN_75
	} scan_mode_e;

	// Limited range bounds of BT.601 video levels
	localparam logic [7:0] Y_MIN = 8'd16;
	localparam logic [7:0] Y_MAX = 8'd235;
	localparam logic [7:0] C_MIN = 8'd16;
	localparam logic [7:0] C_MAX = 8'd240;

	// Fixed point coefficients, result scaled by 256 for 8-bit levels
	// Inputs are 6 bits, so the sums fit in 19 bits
	localparam logic [18:0] Y_K0 = 19'd4096;
	localparam logic [18:0] Y_KR = 19'd264;
	localparam logic [18:0] Y_KG = 19'd516;
	localparam logic [18:0] Y_KB = 19'd100;
	localparam logic [18:0] PB_K0 = 19'd32768;
	localparam logic [18:0] PB_KR = 19'd152;
	localparam logic [18:0] PB_KG = 19'd296;
	localparam logic [18:0] PB_KB = 19'd448;
	localparam logic [18:0] PR_K0 = 19'd32768;
	localparam logic [18:0] PR_KR = 19'd448;
	localparam logic [18:0] PR_KG = 19'd376;
	localparam logic [18:0] PR_KB = 19'd72;

	// Stretch a clamped level from 16..240 onto the full 6-bit range
	function automatic logic [OUT_BITS-1:0] full_range(input logic [7:0] v);
		logic [13:0] scaled;
		// Offset removed, then times 64
		scaled = {v - Y_MIN, 6'b000000};
		// Floor division by the 225 step span
		return OUT_BITS'(scaled / 14'd225);
	endfunction

endpackage

//--- design/video_if.sv
// One pixel stream between the video blocks
// No back-pressure, ce marks a valid pixel for one cycle
interface video_if #(
	parameter int W = 6
);

	// Colour components
	logic [W-1:0] r;
	logic [W-1:0] g;
	logic [W-1:0] b;

	// Sync levels, positive pulses
	logic hs;
	logic vs;

	// Pixel strobe
	logic ce;

	// Driving side
	modport src (
		output r, g, b,
		output hs, vs, ce
	);

	// Receiving side
	modport snk (
		input r, g, b,
		input hs, vs, ce
	);

endinterface

//--- design/scandoubler.sv
module scandoubler #(
	parameter int LINE_LENGTH = 768,
	parameter int HALF_DEPTH = 0,
	localparam int IN_BITS = (HALF_DEPTH != 0) ? 3 : 6
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               ce_pix,
	input  logic [IN_BITS-1:0] r,
	input  logic [IN_BITS-1:0] g,
	input  logic [IN_BITS-1:0] b,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               line_start,
	video_if.src               out
);

	// Buffer address width, and a cycle counter wide enough for a whole line
	localparam int AW = $clog2(LINE_LENGTH);
	localparam int CW = AW + 4;

	logic               hs_d;
	logic               ls_d;
	logic               hs_rise;
	logic               hs_fall;
	logic               ls_fall;
	logic               wr_sel;
	logic               wr_half;
	logic               wr_en;
	logic [AW:0]        wr_addr;
	logic [AW:0]        wr_idx;
	logic [CW-1:0]      period_cnt;
	logic [CW-1:0]      line_period;
	logic [CW-1:0]      ls_ofs;
	logic [CW-1:0]      hs_width;
	logic [CW-1:0]      rd_cnt;
	logic [CW-1:0]      rd_pos;
	logic [CW-1:0]      ofs_half;
	logic               rd_second;
	logic               rd_act;
	logic               rd_ce;
	logic [3*IN_BITS-1:0] buf_mem [2][LINE_LENGTH];

	// Edges of the input syncs
	assign hs_rise = hsync & ~hs_d;
	assign hs_fall = ~hsync & hs_d;
	assign ls_fall = ~line_start & ls_d;

	// Write position restarts at line start; the new half is taken on the hsync edge itself
	assign wr_idx  = (hs_rise || ls_fall) ? '0 : wr_addr;
	assign wr_half = hs_rise ? ~wr_sel : wr_sel;
	assign wr_en   = ce_pix && (wr_idx < LINE_LENGTH);

	// Visible part starts half as far into the doubled line
	assign ofs_half = {1'b0, ls_ofs[CW-1:1]};
	assign rd_pos   = rd_cnt - ofs_half;
	assign rd_act   = (rd_cnt >= ofs_half) && (rd_pos[CW-1:1] < LINE_LENGTH);
	// Two cycles per output pixel
	assign rd_ce    = rd_act && !rd_pos[0];

	// Input line timing, measured in clk_sys cycles
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_d        <= 1'b0;
			ls_d        <= 1'b0;
			period_cnt  <= '0;
			line_period <= '0;
			ls_ofs      <= '0;
			hs_width    <= '0;
			wr_sel      <= 1'b0;
			wr_addr     <= '0;
		end else begin
			hs_d    <= hsync;
			ls_d    <= line_start;
			wr_sel  <= wr_half;
			wr_addr <= wr_en ? wr_idx + 1'b1 : wr_idx;
			if (hs_rise) begin
				line_period <= period_cnt;
				period_cnt  <= CW'(1);
			end else begin
				period_cnt <= period_cnt + 1'b1;
			end
			// Sync width and picture offset, both counted from hsync rise
			if (hs_fall)
				hs_width <= period_cnt;
			if (ls_fall)
				ls_ofs <= period_cnt;
		end
	end

	// Store the incoming line
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			buf_mem[wr_half][wr_idx[AW-1:0]] <= {r, g, b};
	end

	// Read timing, two output lines per input line
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_cnt    <= '0;
			rd_second <= 1'b0;
		end else if (hs_rise) begin
			rd_cnt    <= '0;
			rd_second <= 1'b0;
		end else if (!rd_second && (rd_cnt == (line_period >> 1) - 1'b1)) begin
			// Second pass over the same stored line
			rd_cnt    <= '0;
			rd_second <= 1'b1;
		end else begin
			rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// Output stage
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			out.hs <= 1'b0;
			out.vs <= 1'b0;
			out.ce <= 1'b0;
		end else begin
			out.ce <= rd_ce;
			// Half of the measured input pulse
			out.hs <= rd_cnt < (hs_width >> 1);
			out.vs <= vsync;
		end
	end

	// Pixel data from the half not being written
	always_ff @(posedge clk_sys) begin
		if (rd_act)
			{out.r, out.g, out.b} <= buf_mem[~wr_sel][rd_pos[AW:1]];
	end

endmodule

//--- design/video_mixer.sv
module video_mixer #(
	parameter int HALF_DEPTH = 0,
	localparam int IN_BITS = (HALF_DEPTH != 0) ? 3 : 6
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	video_if.snk                 doubled,
	input  logic [IN_BITS-1:0]   r,
	input  logic [IN_BITS-1:0]   g,
	input  logic [IN_BITS-1:0]   b,
	input  logic                 hsync,
	input  logic                 vsync,
	input  logic                 ce_pix,
	input  logic                 scandoubler_off,
	input  logic                 mono,
	input  video_pkg::scan_mode_e scanlines,
	video_if.src                 out
);

	localparam int OB = video_pkg::OUT_BITS;

	logic [IN_BITS-1:0] rt;
	logic [IN_BITS-1:0] gt;
	logic [IN_BITS-1:0] bt;
	logic               hs;
	logic               vs;
	logic               ce;
	logic [OB-1:0]      r6;
	logic [OB-1:0]      g6;
	logic [OB-1:0]      b6;
	logic               old_hs;
	logic               old_vs;
	logic               scan_flag;
	video_pkg::scan_mode_e scan_now;

	// Darken one component
	function automatic logic [OB-1:0] darken(
		input logic [OB-1:0]         c,
		input video_pkg::scan_mode_e mode
	);
		case (mode)
			// 1/2 + 1/4
			video_pkg::SCAN_25: return (c >> 1) + (c >> 2);
			video_pkg::SCAN_50: return c >> 1;
			video_pkg::SCAN_75: return c >> 2;
			default:            return c;
		endcase
	endfunction

	// Direct 15 kHz input or the doubled stream
	assign rt = scandoubler_off ? r : doubled.r;
	assign gt = scandoubler_off ? g : doubled.g;
	assign bt = scandoubler_off ? b : doubled.b;
	assign hs = scandoubler_off ? hsync : doubled.hs;
	assign vs = scandoubler_off ? vsync : doubled.vs;
	assign ce = scandoubler_off ? ce_pix : doubled.ce;

	// Depth expansion to the output width
	if (HALF_DEPTH != 0) begin : g_half
		always_comb begin
			if (mono) begin
				// Six bit grey level packed as {g, r}
				r6 = {gt, rt};
				g6 = {gt, rt};
				b6 = {gt, rt};
			end else begin
				// Bit repetition keeps full scale at 63
				r6 = {rt, rt};
				g6 = {gt, gt};
				b6 = {bt, bt};
			end
		end
	end else begin : g_full
		assign r6 = rt;
		assign g6 = gt;
		assign b6 = bt;
	end

	// Every second line is darkened, frame starts undarkened
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_hs    <= 1'b0;
			old_vs    <= 1'b0;
			scan_flag <= 1'b0;
		end else begin
			old_hs <= hs;
			old_vs <= vs;
			if (old_vs && !vs)
				scan_flag <= 1'b0;
			else if (old_hs && !hs)
				scan_flag <= ~scan_flag;
		end
	end

	assign scan_now = scan_flag ? scanlines : video_pkg::SCAN_NONE;

	// Single register stage
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			out.r  <= '0;
			out.g  <= '0;
			out.b  <= '0;
			out.hs <= 1'b0;
			out.vs <= 1'b0;
			out.ce <= 1'b0;
		end else begin
			out.r  <= darken(r6, scan_now);
			out.g  <= darken(g6, scan_now);
			out.b  <= darken(b6, scan_now);
			out.hs <= hs;
			out.vs <= vs;
			out.ce <= ce;
		end
	end

endmodule

//--- design/ypbpr_encoder.sv
module ypbpr_encoder (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	video_if.snk                          pix,
	input  logic                          ypbpr,
	input  logic                          ypbpr_full,
	input  logic                          scandoubler_off,
	output logic [video_pkg::OUT_BITS-1:0] vga_r,
	output logic [video_pkg::OUT_BITS-1:0] vga_g,
	output logic [video_pkg::OUT_BITS-1:0] vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs
);

	localparam int OB = video_pkg::OUT_BITS;

	logic [18:0]   y_sum;
	logic [18:0]   pb_sum;
	logic [18:0]   pr_sum;
	logic [7:0]    y_c;
	logic [7:0]    pb_c;
	logic [7:0]    pr_c;
	logic [OB-1:0] r_n;
	logic [OB-1:0] g_n;
	logic [OB-1:0] b_n;
	logic          csync;

	// Limit a 10-bit level to the legal video range
	function automatic logic [7:0] clamp(
		input logic [9:0] v,
		input logic [7:0] lo,
		input logic [7:0] hi
	);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v[7:0];
	endfunction

	// BT.601 matrix, all terms stay positive for 6-bit inputs
	assign y_sum = video_pkg::Y_K0
		+ video_pkg::Y_KR * pix.r
		+ video_pkg::Y_KG * pix.g
		+ video_pkg::Y_KB * pix.b;
	assign pb_sum = video_pkg::PB_K0
		- video_pkg::PB_KR * pix.r
		- video_pkg::PB_KG * pix.g
		+ video_pkg::PB_KB * pix.b;
	assign pr_sum = video_pkg::PR_K0
		+ video_pkg::PR_KR * pix.r
		- video_pkg::PR_KG * pix.g
		- video_pkg::PR_KB * pix.b;

	// Integer part of each level
	assign y_c  = clamp(y_sum[17:8], video_pkg::Y_MIN, video_pkg::Y_MAX);
	assign pb_c = clamp(pb_sum[17:8], video_pkg::C_MIN, video_pkg::C_MAX);
	assign pr_c = clamp(pr_sum[17:8], video_pkg::C_MIN, video_pkg::C_MAX);

	// Component order on the pins is Pr, Y, Pb
	always_comb begin
		if (!ypbpr) begin
			r_n = pix.r;
			g_n = pix.g;
			b_n = pix.b;
		end else if (ypbpr_full) begin
			r_n = video_pkg::full_range(pr_c);
			g_n = video_pkg::full_range(y_c);
			b_n = video_pkg::full_range(pb_c);
		end else begin
			// Top bits of the limited range level
			r_n = pr_c[7:2];
			g_n = y_c[7:2];
			b_n = pb_c[7:2];
		end
	end

	// 15 kHz output and YPbPr both want composite sync
	assign csync = scandoubler_off | ypbpr;

	// Pin register, syncs are active low on the connector
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= r_n;
			vga_g  <= g_n;
			vga_b  <= b_n;
			vga_hs <= csync ? ~(pix.hs ^ pix.vs) : ~pix.hs;
			// VS pin idles high when sync is composite
			vga_vs <= csync ? 1'b1 : ~pix.vs;
		end
	end

endmodule

//--- design/video_out_top.sv
module video_out_top #(
	parameter int LINE_LENGTH = 768,
	parameter int HALF_DEPTH = 0,
	localparam int IN_BITS = (HALF_DEPTH != 0) ? 3 : 6
) (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          ce_pix,
	input  logic [IN_BITS-1:0]            r,
	input  logic [IN_BITS-1:0]            g,
	input  logic [IN_BITS-1:0]            b,
	input  logic                          hsync,
	input  logic                          vsync,
	input  logic                          line_start,
	input  video_pkg::scan_mode_e         scanlines,
	input  logic                          scandoubler_off,
	input  logic                          mono,
	input  logic                          ypbpr,
	input  logic                          ypbpr_full,
	output logic [video_pkg::OUT_BITS-1:0] vga_r,
	output logic [video_pkg::OUT_BITS-1:0] vga_g,
	output logic [video_pkg::OUT_BITS-1:0] vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs
);

	// Doubled stream at input depth
	video_if #(.W(IN_BITS)) sd_bus ();

	// Mixed stream at output depth
	video_if #(.W(video_pkg::OUT_BITS)) mix_bus ();

	// Line buffer, 15 kHz to 31 kHz
	scandoubler #(
		.LINE_LENGTH (LINE_LENGTH),
		.HALF_DEPTH  (HALF_DEPTH)
	) u_scandoubler (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ce_pix     (ce_pix),
		.r          (r),
		.g          (g),
		.b          (b),
		.hsync      (hsync),
		.vsync      (vsync),
		.line_start (line_start),
		.out        (sd_bus.src)
	);

	// Source select, depth expansion and scanlines
	video_mixer #(
		.HALF_DEPTH (HALF_DEPTH)
	) u_mixer (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.doubled         (sd_bus.snk),
		.r               (r),
		.g               (g),
		.b               (b),
		.hsync           (hsync),
		.vsync           (vsync),
		.ce_pix          (ce_pix),
		.scandoubler_off (scandoubler_off),
		.mono            (mono),
		.scanlines       (scanlines),
		.out             (mix_bus.src)
	);

	// Colour space and pin syncs
	ypbpr_encoder u_encoder (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.pix             (mix_bus.snk),
		.ypbpr           (ypbpr),
		.ypbpr_full      (ypbpr_full),
		.scandoubler_off (scandoubler_off),
		.vga_r           (vga_r),
		.vga_g           (vga_g),
		.vga_b           (vga_b),
		.vga_hs          (vga_hs),
		.vga_vs          (vga_vs)
	);

endmodule

//--- sim/tb_video_out.sv
module tb_video_out;
	timeunit 1ns;
	timeprecision 1ps;

	// 128 cycles per line, 80 lines per frame
	localparam int LINE_CYC = 128;
	localparam int FRAME_LINES = 80;
	// Six frames of run time plus margin
	localparam int CYCLE_LIMIT = 6 * FRAME_LINES * LINE_CYC + 4096;

	logic clk_sys = 1'b0;
	logic rst_n;
	logic ce_pix;
	logic [5:0] r;
	logic [5:0] g;
	logic [5:0] b;
	logic hsync;
	logic vsync;
	logic line_start;
	video_pkg::scan_mode_e scanlines;
	logic scandoubler_off;
	logic mono;
	logic ypbpr;
	logic ypbpr_full;
	logic [5:0] vga_r;
	logic [5:0] vga_g;
	logic [5:0] vga_b;
	logic vga_hs;
	logic vga_vs;

	// Frame generator state
	logic gen_on = 1'b0;
	int pos = 0;
	int line = 0;
	int col_src = 0;
	logic [5:0] fill_r = '0;
	logic [5:0] fill_g = '0;
	logic [5:0] fill_b = '0;
	logic [5:0] prev_col = '0;
	logic mid_pt = 1'b0;
	logic line_begin = 1'b0;

	// Checker enables and reference state
	logic in_reset = 1'b0;
	logic chk_sync = 1'b0;
	logic chk_pass = 1'b0;
	logic chk_scan = 1'b0;
	logic chk_dbl = 1'b0;
	logic chk_ypb = 1'b0;
	logic hs_prev = 1'b0;
	logic vs_prev = 1'b0;
	logic odd_line = 1'b0;
	logic vhs_d = 1'b1;
	int hs_falls = 0;

	int unsigned seed = 42411;
	int cycles = 0;
	int errors = 0;
	int err_start = 0;
	int tests = 0;
	string test_name = "reset";

	video_out_top #(
		.LINE_LENGTH (64),
		.HALF_DEPTH  (0)
	) uut (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.ce_pix          (ce_pix),
		.r               (r),
		.g               (g),
		.b               (b),
		.hsync           (hsync),
		.vsync           (vsync),
		.line_start      (line_start),
		.scanlines       (scanlines),
		.scandoubler_off (scandoubler_off),
		.mono            (mono),
		.ypbpr           (ypbpr),
		.ypbpr_full      (ypbpr_full),
		.vga_r           (vga_r),
		.vga_g           (vga_g),
		.vga_b           (vga_b),
		.vga_hs          (vga_hs),
		.vga_vs          (vga_vs)
	);

	always #20 clk_sys = ~clk_sys;

	function automatic logic [5:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[21:16];
	endfunction

	// Constant colour of one input line that differs from its neighbours
	function automatic logic [5:0] line_colour(input int ln);
		return 6'((ln * 7 + 3) & 63);
	endfunction

	function automatic logic [5:0] scan_expect(
		input logic [5:0]            c,
		input video_pkg::scan_mode_e mode,
		input logic                  odd
	);
		if (!odd)
			return c;
		case (mode)
			video_pkg::SCAN_25: return c / 2 + c / 4;
			video_pkg::SCAN_50: return c / 2;
			video_pkg::SCAN_75: return c / 4;
			default:            return c;
		endcase
	endfunction

	function automatic int clip(input int v, input int lo, input int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	// Limited level keeps the top 6 bits, full range stretches 16..240 onto 0..63
	function automatic logic [5:0] level(input int v, input logic full);
		if (full)
			return 6'(((v - 16) * 64) / 225);
		return 6'(v / 4);
	endfunction

	// Expected pins {Pr, Y, Pb} from the BT.601 integer matrix
	function automatic logic [17:0] ypbpr_ref(
		input int   rv,
		input int   gv,
		input int   bv,
		input logic full
	);
		int y;
		int pb;
		int pr;
		y  = ((4096 + 264 * rv + 516 * gv + 100 * bv) >> 8) & 1023;
		pb = ((32768 - 152 * rv - 296 * gv + 448 * bv) >> 8) & 1023;
		pr = ((32768 + 448 * rv - 376 * gv - 72 * bv) >> 8) & 1023;
		y  = clip(y, 16, 235);
		pb = clip(pb, 16, 240);
		pr = clip(pr, 16, 240);
		return {level(pr, full), level(y, full), level(pb, full)};
	endfunction

	// 15 kHz frame with a pixel every fourth cycle
	always @(posedge clk_sys) begin
		if (gen_on) begin
			pos <= (pos == LINE_CYC - 1) ? 0 : pos + 1;
			if (pos == LINE_CYC - 1)
				line <= (line == FRAME_LINES - 1) ? 0 : line + 1;
			hsync      <= pos < 12;
			line_start <= pos < 16;
			vsync      <= line < 3;
			ce_pix     <= (pos % 4) == 0;
			mid_pt     <= (pos == 40) || (pos == 104);
			line_begin <= pos == 0;
			prev_col   <= line_colour((line == 0) ? FRAME_LINES - 1 : line - 1);
			if (col_src == 0) begin
				if ((pos % 4) == 0) begin
					r <= lcg_next();
					g <= lcg_next();
					b <= lcg_next();
				end
			end else if (col_src == 1) begin
				r <= fill_r;
				g <= fill_g;
				b <= fill_b;
			end else begin
				r <= line_colour(line);
				g <= line_colour(line);
				b <= line_colour(line);
			end
		end
	end

	// Odd line after a count of hsync falls since the last vsync fall
	always @(posedge clk_sys) begin
		hs_prev <= hsync;
		vs_prev <= vsync;
		if (vs_prev && !vsync)
			odd_line <= 1'b0;
		else if (hs_prev && !hsync)
			odd_line <= ~odd_line;
	end

	// Falls of the pin hsync within one input line
	always @(posedge clk_sys) begin
		vhs_d <= vga_hs;
		if (line_begin)
			hs_falls <= (vhs_d && !vga_hs) ? 1 : 0;
		else if (vhs_d && !vga_hs)
			hs_falls <= hs_falls + 1;
	end

	a_reset: assert property (@(posedge clk_sys)
		in_reset |-> (vga_hs && vga_vs && {vga_r, vga_g, vga_b} == 18'd0))
	else begin
		errors++;
		$display("FAILED %s: expected hs 1 vs 1 rgb 0, actual hs %b vs %b rgb %h",
			test_name, vga_hs, vga_vs, {vga_r, vga_g, vga_b});
	end

	a_bypass_sync: assert property (@(posedge clk_sys) disable iff (!chk_sync)
		vga_hs == ~($past(hsync, 2) ^ $past(vsync, 2)) && vga_vs)
	else begin
		errors++;
		$display("FAILED %s: expected hs %b vs 1, actual hs %b vs %b", test_name,
			~($past(hsync, 2) ^ $past(vsync, 2)), vga_hs, vga_vs);
	end

	a_bypass_rgb: assert property (@(posedge clk_sys) disable iff (!chk_pass)
		{vga_r, vga_g, vga_b} == {$past(r, 2), $past(g, 2), $past(b, 2)})
	else begin
		errors++;
		$display("FAILED %s: expected %h, actual %h", test_name,
			{$past(r, 2), $past(g, 2), $past(b, 2)}, {vga_r, vga_g, vga_b});
	end

	a_scan: assert property (@(posedge clk_sys) disable iff (!chk_scan)
		{vga_r, vga_g, vga_b} == {
			scan_expect($past(r, 2), $past(scanlines, 2), $past(odd_line, 2)),
			scan_expect($past(g, 2), $past(scanlines, 2), $past(odd_line, 2)),
			scan_expect($past(b, 2), $past(scanlines, 2), $past(odd_line, 2))})
	else begin
		errors++;
		$display("FAILED %s: expected %h, actual %h", test_name, {
			scan_expect($past(r, 2), $past(scanlines, 2), $past(odd_line, 2)),
			scan_expect($past(g, 2), $past(scanlines, 2), $past(odd_line, 2)),
			scan_expect($past(b, 2), $past(scanlines, 2), $past(odd_line, 2))},
			{vga_r, vga_g, vga_b});
	end

	a_dbl_colour: assert property (@(posedge clk_sys) disable iff (!chk_dbl)
		mid_pt |-> {vga_r, vga_g, vga_b} == {prev_col, prev_col, prev_col})
	else begin
		errors++;
		$display("FAILED %s: expected %h, actual %h", test_name,
			{prev_col, prev_col, prev_col}, {vga_r, vga_g, vga_b});
	end

	a_dbl_hs: assert property (@(posedge clk_sys) disable iff (!chk_dbl)
		line_begin |-> hs_falls == 2)
	else begin
		errors++;
		$display("FAILED %s: expected 2 hsync falls, actual %0d", test_name, hs_falls);
	end

	a_dbl_vs: assert property (@(posedge clk_sys) disable iff (!chk_dbl)
		vga_vs == !$past(vsync, 3))
	else begin
		errors++;
		$display("FAILED %s: expected vs %b, actual %b", test_name,
			!$past(vsync, 3), vga_vs);
	end

	a_ypbpr: assert property (@(posedge clk_sys) disable iff (!chk_ypb)
		{vga_r, vga_g, vga_b} == ypbpr_ref($past(r, 2), $past(g, 2), $past(b, 2), 1'b0))
	else begin
		errors++;
		$display("FAILED %s: expected %h, actual %h", test_name,
			ypbpr_ref($past(r, 2), $past(g, 2), $past(b, 2), 1'b0),
			{vga_r, vga_g, vga_b});
	end

	task automatic wait_lines(input int n);
		repeat (n * LINE_CYC) @(posedge clk_sys);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_start = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == err_start)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, errors - err_start);
	endtask

	// Hold one colour long enough to reach the pins, then compare mid cycle
	task automatic full_range_check(input logic [5:0] rv, input logic [5:0] gv,
			input logic [5:0] bv);
		logic [17:0] exp;
		fill_r <= rv;
		fill_g <= gv;
		fill_b <= bv;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		exp = ypbpr_ref(rv, gv, bv, 1'b1);
		if ({vga_r, vga_g, vga_b} !== exp) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", test_name, exp,
				{vga_r, vga_g, vga_b});
		end
		@(posedge clk_sys);
	endtask

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped, the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		ce_pix = 1'b0;
		r = '0;
		g = '0;
		b = '0;
		hsync = 1'b0;
		vsync = 1'b0;
		line_start = 1'b0;
		scanlines = video_pkg::SCAN_NONE;
		scandoubler_off = 1'b1;
		mono = 1'b0;
		ypbpr = 1'b0;
		ypbpr_full = 1'b0;

		// Reset over three edges and checked through the first edge out of reset
		start_test("reset");
		@(posedge clk_sys);
		in_reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);
		gen_on <= 1'b1;
		@(posedge clk_sys);
		in_reset <= 1'b0;
		end_test();

		start_test("bypass");
		wait_lines(2);
		chk_sync <= 1'b1;
		chk_pass <= 1'b1;
		wait_lines(20);
		chk_pass <= 1'b0;
		end_test();

		start_test("scanlines");
		fill_r <= 6'd45;
		fill_g <= 6'd27;
		fill_b <= 6'd62;
		col_src <= 1;
		chk_scan <= 1'b1;
		scanlines <= video_pkg::SCAN_25;
		wait_lines(42);
		scanlines <= video_pkg::SCAN_50;
		wait_lines(42);
		scanlines <= video_pkg::SCAN_75;
		wait_lines(42);
		chk_scan <= 1'b0;
		scanlines <= video_pkg::SCAN_NONE;
		end_test();

		// Doubled 31 kHz stream with separate sync
		start_test("line_doubling");
		col_src <= 2;
		chk_sync <= 1'b0;
		@(posedge clk_sys);
		scandoubler_off <= 1'b0;
		wait_lines(2);
		chk_dbl <= 1'b1;
		wait_lines(84);
		chk_dbl <= 1'b0;
		@(posedge clk_sys);
		scandoubler_off <= 1'b1;
		end_test();

		start_test("ypbpr_limited");
		col_src <= 0;
		ypbpr <= 1'b1;
		wait_lines(2);
		chk_sync <= 1'b1;
		chk_ypb <= 1'b1;
		wait_lines(20);
		chk_ypb <= 1'b0;
		end_test();

		start_test("ypbpr_full");
		col_src <= 1;
		ypbpr_full <= 1'b1;
		full_range_check(6'd0, 6'd0, 6'd0);
		full_range_check(6'd63, 6'd63, 6'd63);
		full_range_check(6'd63, 6'd0, 6'd0);
		full_range_check(6'd0, 6'd63, 6'd0);
		full_range_check(6'd0, 6'd0, 6'd63);
		repeat (40)
			full_range_check(lcg_next(), lcg_next(), lcg_next());
		end_test();

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- build.f
design/video_pkg.sv
design/video_if.sv
design/scandoubler.sv
design/video_mixer.sv
design/ypbpr_encoder.sv
design/video_out_top.sv
sim/tb_video_out.sv

//--- Bender.yml
package:
  name: video_out

sources:
  - design/video_pkg.sv
  - design/video_if.sv
  - design/scandoubler.sv
  - design/video_mixer.sv
  - design/ypbpr_encoder.sv
  - design/video_out_top.sv
  - target: test
    files:
      - sim/tb_video_out.sv
